// File: Bender.yml
package:
  name: uart_periph

sources:
  - common/uart_pkg.sv
  - hw/uart/uart_fifo.sv
  - hw/uart/uart_tx.sv
  - hw/uart/uart_rx.sv
  - hw/uart_bus_regs.sv
  - hw/uart_periph_top.sv
  - target: simulation
    files:
      - sim/tb_uart_periph.sv

// File: common/uart_pkg.sv
// serial port widths, register map, reset defaults and payload types
package uart_pkg;

   // host bus
   localparam int BUS_DATA_W = 64;
   localparam int BUS_BE_W   = 8;
   localparam int BUS_ADDR_W = 14;

   // register select field inside the bus address
   localparam int REG_SEL_HI = 13;
   localparam int REG_SEL_LO = 12;

   localparam logic [1:0] REG_DATA      = 2'd0; // rx head and status, tx push
   localparam logic [1:0] REG_POP_LEVEL = 2'd1; // fifo levels, rx pop
   localparam logic [1:0] REG_BAUD      = 2'd2; // clocks per bit
   localparam logic [1:0] REG_SPARE     = 2'd3;

   // bit timing
   localparam int BAUD_W       = 16;
   localparam int BAUD_DEFAULT = 54;

   // queues
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_LVL_W = 5; // holds 0 to FIFO_DEPTH

   // receive line conditioning
   localparam int SYNC_STAGES = 2;

   typedef logic [7:0] uart_byte_t;

   // one received frame as kept in the rx queue
   typedef struct packed {
      logic       frame_err; // stop bit was low
      uart_byte_t data;
   } rx_entry_t;

   typedef logic [BAUD_W-1:0] baud_t;

   typedef logic [FIFO_LVL_W-1:0] fifo_lvl_t;

endpackage

// File: hw/uart/uart_fifo.sv
// synchronous queue with typed entries, level count and full/empty flags
`timescale 1ns/100ps

module uart_fifo #(
   parameter type payload_t = logic [7:0]
)
(
   input  logic                msoc_clk,
   input  logic                rstn,
   input  logic                push_i,
   input  payload_t            data_i,
   input  logic                pop_i,
   output payload_t            head_o,
   output logic                empty_o,
   output logic                full_o,
   output uart_pkg::fifo_lvl_t level_o
);

   payload_t                        mem [uart_pkg::FIFO_DEPTH];
   logic [uart_pkg::FIFO_LVL_W-2:0] wr_ptr_q, rd_ptr_q; // wrap at depth
   uart_pkg::fifo_lvl_t             level_q;
   logic                            do_push, do_pop;

   assign empty_o = (level_q == '0);
   assign full_o  = (level_q == uart_pkg::FIFO_LVL_W'(uart_pkg::FIFO_DEPTH));
   assign level_o = level_q;
   assign head_o  = mem[rd_ptr_q]; // valid while not empty

   assign do_push = push_i & ~full_o;  // drop when full
   assign do_pop  = pop_i & ~empty_o;  // ignore when empty

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q; // both or neither
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= data_i;
   end

   a_level_bound : assert property (@(posedge msoc_clk) disable iff (!rstn)
      level_q <= uart_pkg::FIFO_LVL_W'(uart_pkg::FIFO_DEPTH))
      else $error("fifo level above depth");

endmodule

// File: hw/uart/uart_rx.sv
// receiver: synchronizer, 3-sample majority, start check, mid-bit sampling
`timescale 1ns/100ps

module uart_rx
(
   input  logic                msoc_clk,
   input  logic                rstn,
   input  uart_pkg::baud_t     baud_i,
   input  logic                uart_rx_i,
   output logic                rx_push_o,
   output uart_pkg::rx_entry_t rx_entry_o
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   logic [uart_pkg::SYNC_STAGES-1:0] sync_q;
   logic [2:0]                       hist_q;     // last three synced samples
   logic                             maj, maj_q, maj_prev_q;
   rx_state_t                        state_q;
   uart_pkg::baud_t                  div_q, baud_cnt_q, half;
   logic [2:0]                       bit_cnt_q;
   uart_pkg::uart_byte_t             data_q;
   uart_pkg::rx_entry_t              entry_q;
   logic                             push_q;
   logic                             sample;

   assign maj  = (hist_q[0] & hist_q[1]) | (hist_q[0] & hist_q[2]) | (hist_q[1] & hist_q[2]);
   assign half = div_q >> 1;

   // start check waits half a bit, the rest wait a full bit
   assign sample = (state_q == RX_START) ? (baud_cnt_q == half - 1'b1) :
                   (state_q != RX_IDLE) && (baud_cnt_q == div_q - 1'b1);

   assign rx_push_o  = push_q;
   assign rx_entry_o = entry_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         sync_q     <= '1;
         hist_q     <= '1;
         maj_q      <= 1'b1;
         maj_prev_q <= 1'b1;
      end
      else
      begin
         sync_q     <= {sync_q[uart_pkg::SYNC_STAGES-2:0], uart_rx_i};
         hist_q     <= {hist_q[1:0], sync_q[uart_pkg::SYNC_STAGES-1]};
         maj_q      <= maj;
         maj_prev_q <= maj_q; // for falling edge
      end
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q    <= RX_IDLE;
         div_q      <= uart_pkg::BAUD_W'(uart_pkg::BAUD_DEFAULT);
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         push_q     <= 1'b0;
      end
      else
      begin
         push_q <= 1'b0;
         case (state_q)
            RX_IDLE:
            begin
               if (maj_prev_q && !maj_q)
               begin
                  div_q      <= baud_i;
                  baud_cnt_q <= '0;
                  state_q    <= RX_START;
               end
            end
            RX_START:
            begin
               if (sample)
               begin
                  baud_cnt_q <= '0;
                  bit_cnt_q  <= '0;
                  state_q    <= maj_q ? RX_IDLE : RX_DATA; // glitch if high again
               end
               else
                  baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            RX_DATA:
            begin
               if (sample)
               begin
                  baud_cnt_q <= '0;
                  bit_cnt_q  <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7)
                     state_q <= RX_STOP;
               end
               else
                  baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            RX_STOP:
            begin
               if (sample)
               begin
                  push_q  <= 1'b1;
                  state_q <= RX_IDLE;
               end
               else
                  baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (sample && (state_q == RX_DATA))
         data_q <= {maj_q, data_q[7:1]}; // lsb arrives first
      if (sample && (state_q == RX_STOP))
      begin
         entry_q.data      <= data_q;
         entry_q.frame_err <= ~maj_q;
      end
   end

   a_push_single : assert property (@(posedge msoc_clk) disable iff (!rstn)
      rx_push_o |=> !rx_push_o)
      else $error("rx push held for two cycles");

endmodule

// File: hw/uart/uart_tx.sv
// transmit sequencer: pops the queue and sends 8N1 frames, LSB first
`timescale 1ns/100ps

module uart_tx
(
   input  logic                 msoc_clk,
   input  logic                 rstn,
   input  uart_pkg::baud_t      baud_i,
   input  logic                 fifo_empty_i,
   input  uart_pkg::uart_byte_t fifo_head_i,
   output logic                 fifo_pop_o,
   output logic                 uart_tx_o
);

   typedef enum logic [1:0] {TX_IDLE, TX_POP, TX_SEND} tx_state_t;

   tx_state_t       state_q;
   uart_pkg::baud_t div_q;      // divisor frozen for the frame
   uart_pkg::baud_t baud_cnt_q;
   logic [3:0]      bit_cnt_q;  // 0 is start, 9 is stop
   logic [8:0]      shift_q;    // stop bit above the data
   logic            line_q;
   logic            bit_end;

   assign bit_end    = (state_q == TX_SEND) && (baud_cnt_q == div_q - 1'b1);
   assign fifo_pop_o = (state_q == TX_POP);
   assign uart_tx_o  = line_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q    <= TX_IDLE;
         div_q      <= uart_pkg::BAUD_W'(uart_pkg::BAUD_DEFAULT);
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
         line_q     <= 1'b1; // line idles high
      end
      else
      begin
         case (state_q)
            TX_IDLE:
            begin
               if (!fifo_empty_i)
                  state_q <= TX_POP;
            end
            TX_POP:
            begin
               div_q      <= baud_i;
               baud_cnt_q <= '0;
               bit_cnt_q  <= '0;
               line_q     <= 1'b0; // start bit
               state_q    <= TX_SEND;
            end
            TX_SEND:
            begin
               if (bit_end)
               begin
                  baud_cnt_q <= '0;
                  if (bit_cnt_q == 4'd9)
                     state_q <= TX_IDLE; // stop bit done
                  else
                  begin
                     line_q    <= shift_q[0];
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                  end
               end
               else
                  baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == TX_POP)
         shift_q <= {1'b1, fifo_head_i}; // head still valid during pop
      else if (bit_end)
         shift_q <= {1'b1, shift_q[8:1]};
   end

   a_idle_high : assert property (@(posedge msoc_clk) disable iff (!rstn)
      (state_q == TX_IDLE) |-> uart_tx_o)
      else $error("tx line low while sequencer idle");

endmodule

// File: hw/uart_bus_regs.sv
// bus register decode: tx push, rx pop, baud divisor register, read mux
`timescale 1ns/100ps

module uart_bus_regs
(
   input  logic                           msoc_clk,
   input  logic                           rstn,
   input  logic                           bus_en_i,
   input  logic [uart_pkg::BUS_BE_W-1:0]   bus_we_i,
   input  logic [uart_pkg::BUS_ADDR_W-1:0] bus_addr_i,
   input  logic [uart_pkg::BUS_DATA_W-1:0] bus_wdata_i,
   input  uart_pkg::rx_entry_t            rx_head_i,
   input  logic                           rx_empty_i,
   input  logic                           rx_full_i,
   input  logic                           tx_full_i,
   input  uart_pkg::fifo_lvl_t            rx_level_i,
   input  uart_pkg::fifo_lvl_t            tx_level_i,
   output logic [uart_pkg::BUS_DATA_W-1:0] bus_rdata_o,
   output logic                           tx_push_o,
   output uart_pkg::uart_byte_t           tx_byte_o,
   output logic                           rx_pop_o,
   output uart_pkg::baud_t                baud_o
);

   logic            wr_en;
   logic [1:0]      reg_sel;
   uart_pkg::baud_t baud_q;

   assign wr_en   = bus_en_i & (|bus_we_i); // any byte lane counts as a write
   assign reg_sel = bus_addr_i[uart_pkg::REG_SEL_HI:uart_pkg::REG_SEL_LO];

   // single-cycle strobes, the queues act on them at the next edge
   assign tx_push_o = wr_en && (reg_sel == uart_pkg::REG_DATA);
   assign tx_byte_o = bus_wdata_i[7:0];
   assign rx_pop_o  = wr_en && (reg_sel == uart_pkg::REG_POP_LEVEL);
   assign baud_o    = baud_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_q <= uart_pkg::BAUD_W'(uart_pkg::BAUD_DEFAULT);
      end
      else if (wr_en && (reg_sel == uart_pkg::REG_BAUD))
      begin
         baud_q <= bus_wdata_i[uart_pkg::BAUD_W-1:0];
      end
   end

   // reads follow the address in the same cycle
   always_comb
   begin
      bus_rdata_o = '0;
      case (reg_sel)
         uart_pkg::REG_DATA:
         begin
            bus_rdata_o[7:0] = rx_head_i.data;
            bus_rdata_o[8]   = rx_head_i.frame_err;
            bus_rdata_o[9]   = rx_empty_i;
            bus_rdata_o[10]  = tx_full_i;
            bus_rdata_o[11]  = rx_full_i;
         end
         uart_pkg::REG_POP_LEVEL:
         begin
            bus_rdata_o[4:0]   = rx_level_i;
            bus_rdata_o[20:16] = tx_level_i;
         end
         uart_pkg::REG_BAUD:
         begin
            bus_rdata_o[uart_pkg::BAUD_W-1:0] = baud_q;
         end
         uart_pkg::REG_SPARE:
         begin
            bus_rdata_o = '0; // reserved
         end
         default:
         begin
            bus_rdata_o = '0;
         end
      endcase
   end

   // one register per bus cycle, so push and pop never coincide
   a_push_pop_excl : assert property (@(posedge msoc_clk) disable iff (!rstn)
      !(tx_push_o && rx_pop_o))
      else $error("tx push and rx pop in the same cycle");

endmodule

// File: hw/uart_periph_top.sv
// serial port peripheral top: bus registers, tx/rx queues, transmitter, receiver
`timescale 1ns/100ps

module uart_periph_top
(
   input  logic                           msoc_clk,
   input  logic                           rstn,
   input  logic                           bus_en_i,
   input  logic [uart_pkg::BUS_BE_W-1:0]   bus_we_i,
   input  logic [uart_pkg::BUS_ADDR_W-1:0] bus_addr_i,
   input  logic [uart_pkg::BUS_DATA_W-1:0] bus_wdata_i,
   input  logic                           uart_rx_i,
   output logic [uart_pkg::BUS_DATA_W-1:0] bus_rdata_o,
   output logic                           uart_tx_o,
   output logic                           uart_irq_o
);

   logic                  tx_push, tx_pop, tx_empty, tx_full;
   uart_pkg::uart_byte_t  tx_byte, tx_head;
   uart_pkg::fifo_lvl_t   tx_level;
   logic                  rx_push, rx_pop, rx_empty, rx_full;
   uart_pkg::rx_entry_t   rx_entry, rx_head;
   uart_pkg::fifo_lvl_t   rx_level;
   uart_pkg::baud_t       baud;

   assign uart_irq_o = ~rx_empty; // pending receive data

   uart_bus_regs u_regs (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .bus_en_i    (bus_en_i),
      .bus_we_i    (bus_we_i),
      .bus_addr_i  (bus_addr_i),
      .bus_wdata_i (bus_wdata_i),
      .rx_head_i   (rx_head),
      .rx_empty_i  (rx_empty),
      .rx_full_i   (rx_full),
      .tx_full_i   (tx_full),
      .rx_level_i  (rx_level),
      .tx_level_i  (tx_level),
      .bus_rdata_o (bus_rdata_o),
      .tx_push_o   (tx_push),
      .tx_byte_o   (tx_byte),
      .rx_pop_o    (rx_pop),
      .baud_o      (baud)
   );

   uart_fifo #(.payload_t(uart_pkg::uart_byte_t)) u_tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (tx_push),
      .data_i   (tx_byte),
      .pop_i    (tx_pop),
      .head_o   (tx_head),
      .empty_o  (tx_empty),
      .full_o   (tx_full),
      .level_o  (tx_level)
   );

   uart_fifo #(.payload_t(uart_pkg::rx_entry_t)) u_rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .push_i   (rx_push),
      .data_i   (rx_entry),
      .pop_i    (rx_pop),
      .head_o   (rx_head),
      .empty_o  (rx_empty),
      .full_o   (rx_full),
      .level_o  (rx_level)
   );

   uart_tx u_tx (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .baud_i       (baud),
      .fifo_empty_i (tx_empty),
      .fifo_head_i  (tx_head),
      .fifo_pop_o   (tx_pop),
      .uart_tx_o    (uart_tx_o)
   );

   uart_rx u_rx (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud),
      .uart_rx_i  (uart_rx_i),
      .rx_push_o  (rx_push),
      .rx_entry_o (rx_entry)
   );

endmodule

// File: sim.f
common/uart_pkg.sv
hw/uart/uart_fifo.sv
hw/uart/uart_tx.sv
hw/uart/uart_rx.sv
hw/uart_bus_regs.sv
hw/uart_periph_top.sv
sim/tb_uart_periph.sv

// File: sim/tb_uart_periph.sv
// testbench for the serial port peripheral: clock, reset, bus driver, line model, checks, watchdog
`timescale 1ns/100ps

module tb_uart_periph;

   localparam string TEST_FILE    = "sim/uart_tests.txt";
   localparam int    CLK_PERIOD   = 10;
   localparam int    RESET_CYCLES = 10;
   localparam int    FRAME_BITS   = 10;
   localparam logic [31:0] SEED   = 32'hc0f4;

   logic                                 msoc_clk = 1'b0;
   logic                                 rstn;
   logic                                 bus_en_i;
   logic [uart_pkg::BUS_BE_W-1:0]        bus_we_i;
   logic [uart_pkg::BUS_ADDR_W-1:0]      bus_addr_i;
   logic [uart_pkg::BUS_DATA_W-1:0]      bus_wdata_i;
   logic                                 uart_rx_i;
   logic [uart_pkg::BUS_DATA_W-1:0]      bus_rdata_o;
   logic                                 uart_tx_o;
   logic                                 uart_irq_o;

   logic [7:0]  op_q [$];
   logic [63:0] a_q [$];
   logic [63:0] b_q [$];
   logic [7:0]  tx_bytes [$];   // bytes decoded from uart_tx_o
   int          cur_div = uart_pkg::BAUD_DEFAULT;
   longint      limit_ns;
   logic        loaded = 1'b0;
   logic        mon_busy = 1'b0;
   int          mon_div;
   int          mon_i;
   logic [7:0]  mon_byte;

   uart_periph_top DUT (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .bus_en_i    (bus_en_i),
      .bus_we_i    (bus_we_i),
      .bus_addr_i  (bus_addr_i),
      .bus_wdata_i (bus_wdata_i),
      .uart_rx_i   (uart_rx_i),
      .bus_rdata_o (bus_rdata_o),
      .uart_tx_o   (uart_tx_o),
      .uart_irq_o  (uart_irq_o)
   );

   always #(CLK_PERIOD / 2) msoc_clk = ~msoc_clk;

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic idle_gap(input int n);
      repeat (n)
      begin
         @(posedge msoc_clk);
         bus_en_i <= 1'b0;
         bus_we_i <= '0;
      end
   endtask

   task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
      @(posedge msoc_clk);
      bus_en_i    <= 1'b1;
      bus_we_i    <= '1;
      bus_addr_i  <= addr[uart_pkg::BUS_ADDR_W-1:0];
      bus_wdata_i <= data;
      @(posedge msoc_clk);   // DUT takes the write here
      bus_en_i    <= 1'b0;
      bus_we_i    <= '0;
   endtask

   task automatic bus_read(input logic [63:0] addr, output logic [63:0] data);
      @(posedge msoc_clk);
      bus_en_i   <= 1'b1;
      bus_we_i   <= '0;
      bus_addr_i <= addr[uart_pkg::BUS_ADDR_W-1:0];
      @(negedge msoc_clk);   // read mux settled
      data = bus_rdata_o;
   endtask

   task automatic check_read(input logic [63:0] addr, input logic [63:0] exp_val);
      logic [63:0] got;
      logic [63:0] mask;
      logic        is_data;
      bus_read(addr, got);
      is_data = (addr[uart_pkg::REG_SEL_HI:uart_pkg::REG_SEL_LO] == uart_pkg::REG_DATA);
      mask = '1;
      if (is_data && exp_val[9])
         mask = ~64'h1ff;   // rx head undefined while empty
      assert ((got & mask) === (exp_val & mask))
         else report_fail($sformatf("[ERROR] bus_rdata_o at 0x%h: expected 0x%h got 0x%h",
                                    addr, exp_val & mask, got & mask));
      if (is_data)
      begin
         // interrupt tracks a non-empty rx queue
         assert (uart_irq_o === ~exp_val[9])
            else report_fail($sformatf("[ERROR] uart_irq_o: expected 0x%h got 0x%h",
                                       ~exp_val[9], uart_irq_o));
      end
   endtask

   task automatic send_frame(input logic [7:0] data, input logic stop_bit);
      logic [9:0] frame;
      int         i;
      frame = {stop_bit, data, 1'b0};   // start bit first, lsb next
      for (i = 0; i < FRAME_BITS; i++)
      begin
         @(posedge msoc_clk);
         uart_rx_i <= frame[i];
         repeat (cur_div - 1) @(posedge msoc_clk);
      end
      @(posedge msoc_clk);
      uart_rx_i <= 1'b1;
      repeat (2 * cur_div) @(posedge msoc_clk);   // lets the receiver queue the entry
      @(negedge msoc_clk);
      assert (uart_irq_o === 1'b1)
         else report_fail($sformatf("[ERROR] uart_irq_o: expected 0x1 got 0x%h", uart_irq_o));
   endtask

   task automatic expect_tx(input logic [7:0] exp_byte);
      logic [7:0] got;
      while (tx_bytes.size() == 0)
         @(posedge msoc_clk);
      got = tx_bytes.pop_front();
      assert (got === exp_byte)
         else report_fail($sformatf("[ERROR] uart_tx_o byte: expected 0x%h got 0x%h",
                                    exp_byte, got));
   endtask

   task automatic wait_tx_idle();
      int idle_run;
      idle_run = 0;
      // a queued byte starts its frame within a few cycles, so a long quiet line means done
      while (idle_run < 2 * cur_div + 8)
      begin
         @(negedge msoc_clk);
         if (uart_tx_o === 1'b1 && !mon_busy)
            idle_run++;
         else
            idle_run = 0;
      end
   endtask

   // serial line model for the transmit side, samples each bit near its middle
   always
   begin
      @(negedge uart_tx_o);
      if (rstn === 1'b1)
      begin
         mon_busy = 1'b1;
         mon_div  = cur_div;
         repeat (mon_div / 2) @(negedge msoc_clk);
         assert (uart_tx_o === 1'b0)
            else report_fail("tx start bit did not stay low until mid-bit");
         for (mon_i = 0; mon_i < 8; mon_i++)
         begin
            repeat (mon_div) @(negedge msoc_clk);
            mon_byte[mon_i] = uart_tx_o;
         end
         repeat (mon_div) @(negedge msoc_clk);
         assert (uart_tx_o === 1'b1)
            else report_fail($sformatf("[ERROR] uart_tx_o stop bit: expected 0x1 got 0x%h",
                                       uart_tx_o));
         tx_bytes.push_back(mon_byte);
         mon_busy = 1'b0;
      end
   end

   initial
   begin
      wait (loaded);
      #(limit_ns);
      report_fail("timeout: the tests did not finish within the time limit");
   end

   initial
   begin
      int          fd;
      int          rc;
      int          n;
      int          k;
      int          max_div;
      string       line;
      logic [7:0]  op;
      logic [63:0] fa;
      logic [63:0] fb;
      logic [31:0] rng;
      rstn        = 1'b0;
      bus_en_i    = 1'b0;
      bus_we_i    = '0;
      bus_addr_i  = '0;
      bus_wdata_i = '0;
      uart_rx_i   = 1'b1;   // idle line
      rng         = SEED;
      max_div     = uart_pkg::BAUD_DEFAULT;

      fd = $fopen(TEST_FILE, "r");
      if (fd == 0)
         report_fail("could not open the test file");
      while (!$feof(fd))
      begin
         rc = $fgets(line, fd);
         if (rc != 0 && line.len() > 0 && line[0] != "#")
         begin
            n = $sscanf(line, "%c %h %h", op, fa, fb);
            if (n == 3)
            begin
               op_q.push_back(op);
               a_q.push_back(fa);
               b_q.push_back(fb);
               if (op == "W" && fa[uart_pkg::REG_SEL_HI:uart_pkg::REG_SEL_LO] ==
                   uart_pkg::REG_BAUD && int'(fb[15:0]) > max_div)
                  max_div = int'(fb[15:0]);
            end
         end
      end
      $fclose(fd);
      limit_ns = (longint'(op_q.size()) * 12 * FRAME_BITS * max_div + RESET_CYCLES + 50)
                 * CLK_PERIOD;
      loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge msoc_clk);
      rstn <= 1'b1;
      @(negedge msoc_clk);
      assert (uart_tx_o === 1'b1)
         else report_fail($sformatf("[ERROR] uart_tx_o: expected 0x1 got 0x%h", uart_tx_o));
      assert (uart_irq_o === 1'b0)
         else report_fail($sformatf("[ERROR] uart_irq_o: expected 0x0 got 0x%h", uart_irq_o));

      for (k = 0; k < op_q.size(); k++)
      begin
         idle_gap(int'(rng[1:0]));
         rng = next_rand(rng);
         case (op_q[k])
            "W":
            begin
               bus_write(a_q[k], b_q[k]);
               if (a_q[k][uart_pkg::REG_SEL_HI:uart_pkg::REG_SEL_LO] == uart_pkg::REG_BAUD)
                  cur_div = int'(b_q[k][15:0]);   // line model follows the new divisor
            end
            "R": check_read(a_q[k], b_q[k]);
            "S": send_frame(a_q[k][7:0], b_q[k][0]);
            "T": expect_tx(a_q[k][7:0]);
            "D": wait_tx_idle();
            default: report_fail($sformatf("unknown operation on test line %0d", k + 1));
         endcase
      end

      assert (tx_bytes.size() == 0)
         else report_fail("the transmitter sent bytes that no test line expected");
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: sim/uart_tests.txt
# columns: op code, then two hex fields
# W addr data | R addr expected | S byte stopbit | T byte 0 | D 0 0
R 0000 200
R 2000 36
R 1000 0
R 3000 0
W 2000 8
R 2000 8
W 3000 ff
R 3000 0
W 0000 a5
W 0000 3c
W 0000 81
T a5 0
T 3c 0
T 81 0
D 0 0
R 1000 0
S 5a 1
R 0000 5a
S c3 1
R 1000 2
R 0000 5a
W 1000 0
R 0000 c3
W 1000 0
R 0000 200
S 99 0
R 0000 199
W 1000 0
R 0000 200
S 10 1
S 11 1
S 12 1
S 13 1
S 14 1
S 15 1
S 16 1
S 17 1
S 18 1
S 19 1
S 1a 1
S 1b 1
S 1c 1
S 1d 1
S 1e 1
S 1f 1
S 20 1
R 1000 10
R 0000 810
W 1000 0
R 0000 11
W 1000 0
R 0000 12
W 1000 0
R 0000 13
W 1000 0
R 0000 14
W 1000 0
R 0000 15
W 1000 0
R 0000 16
W 1000 0
R 0000 17
W 1000 0
R 0000 18
W 1000 0
R 0000 19
W 1000 0
R 0000 1a
W 1000 0
R 0000 1b
W 1000 0
R 0000 1c
W 1000 0
R 0000 1d
W 1000 0
R 0000 1e
W 1000 0
R 0000 1f
W 1000 0
R 0000 200
R 1000 0
